/* Bender.yml */
package:
  name: pipeCtrl

export_include_dirs:
  - .

sources:
  - pipeCtrl_pkg.sv
  - hazard.sv
  - stageTags.sv
  - forwardMux.sv
  - pipeCtrl.sv
  - target: simulation
    files:
      - tb_pipeCtrl.sv

/* filelist.f */
+incdir+.
pipeCtrl_pkg.sv
hazard.sv
stageTags.sv
forwardMux.sv
pipeCtrl.sv
tb_pipeCtrl.sv

/* forwardMux.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module forwardMux (
	// decode compare selects
	input  logic                  forwardAD,
	input  logic                  forwardBD,
	// execute operand selects
	input  pipeCtrl_pkg::fwdSel   forwardAE,
	input  pipeCtrl_pkg::fwdSel   forwardBE,
	// register file reads, decode and execute copies
	input  pipeCtrl_pkg::dataWord rdAD,
	input  pipeCtrl_pkg::dataWord rdBD,
	input  pipeCtrl_pkg::dataWord rdAE,
	input  pipeCtrl_pkg::dataWord rdBE,
	// forwarding sources
	input  pipeCtrl_pkg::dataWord aluOutM,
	input  pipeCtrl_pkg::dataWord resultW,
	// selected operands
	output pipeCtrl_pkg::dataWord cmpAD,
	output pipeCtrl_pkg::dataWord cmpBD,
	output pipeCtrl_pkg::dataWord srcAE,
	output pipeCtrl_pkg::dataWord srcBE
);
	import pipeCtrl_pkg::*;

	// three way pick for one execute operand
	// unused code 3 falls back to the register file
	function automatic dataWord pickExe(
		fwdSel   sel,
		dataWord rd,
		dataWord memVal,
		dataWord wbVal
	);
		case (sel)
			`FWD_MEM: pickExe = memVal;
			`FWD_WB:  pickExe = wbVal;
			default:  pickExe = rd;
		endcase
	endfunction

	// branch compare sees the memory stage result only
	assign cmpAD = forwardAD ? aluOutM : rdAD;
	assign cmpBD = forwardBD ? aluOutM : rdBD;

	// alu source operands
	assign srcAE = pickExe(forwardAE, rdAE, aluOutM, resultW);
	assign srcBE = pickExe(forwardBE, rdBE, aluOutM, resultW);

endmodule

/* hazard.sv */
`timescale 1ns/10ps
`include "pipe_defs.svh"

module hazard (
	// decode stage fields
	input  pipeCtrl_pkg::regAddr rsD,
	input  pipeCtrl_pkg::regAddr rtD,
	input  logic                 branchD,
	input  logic                 jrD,
	// execute stage tags
	input  pipeCtrl_pkg::regAddr rsE,
	input  pipeCtrl_pkg::regAddr rtE,
	input  pipeCtrl_pkg::regAddr writeRegE,
	input  logic                 regWriteE,
	input  logic                 memToRegE,
	// memory stage tags
	input  pipeCtrl_pkg::regAddr writeRegM,
	input  logic                 regWriteM,
	input  logic                 memToRegM,
	// writeback stage tags
	input  pipeCtrl_pkg::regAddr writeRegW,
	input  logic                 regWriteW,
	// forward selects
	output logic                 forwardAD,
	output logic                 forwardBD,
	output pipeCtrl_pkg::fwdSel  forwardAE,
	output pipeCtrl_pkg::fwdSel  forwardBE,
	// stall and flush controls
	output logic                 stallF,
	output logic                 stallD,
	output logic                 flushE,
	output logic                 jrStallRead
);
	import pipeCtrl_pkg::*;

	logic loadStall;
	logic branchStall;
	logic jrStallWrite;

	// a later stage is about to write this source
	// reg 0 never counts
	function automatic logic hits(regAddr src, regAddr dst, logic wr);
		hits = wr && (src != '0) && (src == dst);
	endfunction

	// memory stage wins over writeback
	// it holds the newer value
	function automatic fwdSel exeSel(
		regAddr src,
		regAddr dstM,
		logic   wrM,
		regAddr dstW,
		logic   wrW
	);
		if (hits(src, dstM, wrM))
			exeSel = `FWD_MEM;
		else if (hits(src, dstW, wrW))
			exeSel = `FWD_WB;
		else
			exeSel = `FWD_NONE;
	endfunction

	// execute operand forwarding
	assign forwardAE = exeSel(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
	assign forwardBE = exeSel(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

	// branch compare forwarding
	// only the memory stage alu result is usable
	assign forwardAD = hits(rsD, writeRegM, regWriteM);
	assign forwardBD = hits(rtD, writeRegM, regWriteM);

	// load in execute
	// data not there until writeback
	assign loadStall = memToRegE && (rtE == rsD || rtE == rtD);

	// branch resolves in decode
	// producer still in execute, or a load still in memory
	assign branchStall = branchD &&
		((regWriteE && (writeRegE == rsD || writeRegE == rtD)) ||
		 (memToRegM && (writeRegM == rsD || writeRegM == rtD)));

	// jr target read in decode while a load to rs sits in memory
	assign jrStallRead = jrD && memToRegM && (writeRegM == rsD);

	// jalr behind a producer of rs still in execute
	assign jrStallWrite = jrD && regWriteE && (writeRegE == rsD);

	assign stallD = loadStall || branchStall || jrStallRead || jrStallWrite;
	assign stallF = loadStall || branchStall || jrStallRead || jrStallWrite;
	// write stall holds decode only
	// execute is not bubbled
	assign flushE = loadStall || branchStall || jrStallRead;

endmodule

/* pipeCtrl.sv */
`timescale 1ns/10ps

module pipeCtrl (
	input  logic                  clk,
	input  logic                  rstN,
	// decode fields
	input  pipeCtrl_pkg::regAddr  rsD,
	input  pipeCtrl_pkg::regAddr  rtD,
	input  pipeCtrl_pkg::regAddr  writeRegD,
	input  logic                  regWriteD,
	input  logic                  memToRegD,
	input  logic                  branchD,
	input  logic                  jrD,
	// register file reads
	input  pipeCtrl_pkg::dataWord rdAD,
	input  pipeCtrl_pkg::dataWord rdBD,
	// forwarding sources from the datapath
	input  pipeCtrl_pkg::dataWord aluOutM,
	input  pipeCtrl_pkg::dataWord resultW,
	// pipeline controls
	output logic                  stallF,
	output logic                  stallD,
	output logic                  flushE,
	output logic                  jrStallRead,
	// operands
	output pipeCtrl_pkg::dataWord cmpAD,
	output pipeCtrl_pkg::dataWord cmpBD,
	output pipeCtrl_pkg::dataWord srcAE,
	output pipeCtrl_pkg::dataWord srcBE,
	// register file write port
	output pipeCtrl_pkg::regAddr  writeRegW,
	output logic                  regWriteW
);
	import pipeCtrl_pkg::*;

	// execute tags
	regAddr  rsE;
	regAddr  rtE;
	regAddr  writeRegE;
	logic    regWriteE;
	logic    memToRegE;
	dataWord rdAE;
	dataWord rdBE;
	// memory tags
	regAddr  writeRegM;
	logic    regWriteM;
	logic    memToRegM;
	// forward selects
	logic    forwardAD;
	logic    forwardBD;
	fwdSel   forwardAE;
	fwdSel   forwardBE;

	// stage register banks
	stageTags i_stageTags (
		.clk       (clk),
		.rstN      (rstN),
		.flushE    (flushE),
		.rsD       (rsD),
		.rtD       (rtD),
		.writeRegD (writeRegD),
		.regWriteD (regWriteD),
		.memToRegD (memToRegD),
		.rdAD      (rdAD),
		.rdBD      (rdBD),
		.rsE       (rsE),
		.rtE       (rtE),
		.writeRegE (writeRegE),
		.regWriteE (regWriteE),
		.memToRegE (memToRegE),
		.rdAE      (rdAE),
		.rdBE      (rdBE),
		.writeRegM (writeRegM),
		.regWriteM (regWriteM),
		.memToRegM (memToRegM),
		.writeRegW (writeRegW),
		.regWriteW (regWriteW)
	);

	// stall, flush and forward decisions
	hazard i_hazard (
		.rsD         (rsD),
		.rtD         (rtD),
		.branchD     (branchD),
		.jrD         (jrD),
		.rsE         (rsE),
		.rtE         (rtE),
		.writeRegE   (writeRegE),
		.regWriteE   (regWriteE),
		.memToRegE   (memToRegE),
		.writeRegM   (writeRegM),
		.regWriteM   (regWriteM),
		.memToRegM   (memToRegM),
		.writeRegW   (writeRegW),
		.regWriteW   (regWriteW),
		.forwardAD   (forwardAD),
		.forwardBD   (forwardBD),
		.forwardAE   (forwardAE),
		.forwardBE   (forwardBE),
		.stallF      (stallF),
		.stallD      (stallD),
		.flushE      (flushE),
		.jrStallRead (jrStallRead)
	);

	// operand muxes
	forwardMux i_forwardMux (
		.forwardAD (forwardAD),
		.forwardBD (forwardBD),
		.forwardAE (forwardAE),
		.forwardBE (forwardBE),
		.rdAD      (rdAD),
		.rdBD      (rdBD),
		.rdAE      (rdAE),
		.rdBE      (rdBE),
		.aluOutM   (aluOutM),
		.resultW   (resultW),
		.cmpAD     (cmpAD),
		.cmpBD     (cmpBD),
		.srcAE     (srcAE),
		.srcBE     (srcBE)
	);

endmodule

/* pipeCtrl_pkg.sv */
`include "pipe_defs.svh"

package pipeCtrl_pkg;

	// register number
	// gpr 0 reads as zero and is never a forward target
	typedef logic [`REG_ADDR_W-1:0] regAddr;

	// one data value as seen on the operand buses
	typedef logic [`DATA_W-1:0] dataWord;

	// execute stage forward select
	// holds one of the FWD codes
	typedef logic [1:0] fwdSel;

endpackage

/* pipe_defs.svh */
`ifndef PIPE_DEFS_SVH
`define PIPE_DEFS_SVH

// architectural data word width
`define DATA_W 32
// register number width, 32 gprs
`define REG_ADDR_W 5

// execute operand select codes
// operand straight from the register file
`define FWD_NONE 2'd0
// operand from the writeback result
`define FWD_WB 2'd1
// operand from the memory stage alu result
`define FWD_MEM 2'd2

`endif

/* stageTags.sv */
`timescale 1ns/10ps

module stageTags (
	input  logic                  clk,
	input  logic                  rstN,
	// bubble request from hazard
	input  logic                  flushE,
	// decode fields
	input  pipeCtrl_pkg::regAddr  rsD,
	input  pipeCtrl_pkg::regAddr  rtD,
	input  pipeCtrl_pkg::regAddr  writeRegD,
	input  logic                  regWriteD,
	input  logic                  memToRegD,
	input  pipeCtrl_pkg::dataWord rdAD,
	input  pipeCtrl_pkg::dataWord rdBD,
	// execute stage
	output pipeCtrl_pkg::regAddr  rsE,
	output pipeCtrl_pkg::regAddr  rtE,
	output pipeCtrl_pkg::regAddr  writeRegE,
	output logic                  regWriteE,
	output logic                  memToRegE,
	output pipeCtrl_pkg::dataWord rdAE,
	output pipeCtrl_pkg::dataWord rdBE,
	// memory stage
	output pipeCtrl_pkg::regAddr  writeRegM,
	output logic                  regWriteM,
	output logic                  memToRegM,
	// writeback stage
	output pipeCtrl_pkg::regAddr  writeRegW,
	output logic                  regWriteW
);

	// execute bank
	// flush loads an all zero bubble
	// stall alone does not hold here, decode just enters again
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			rsE       <= '0;
			rtE       <= '0;
			writeRegE <= '0;
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
		end else if (flushE) begin
			rsE       <= '0;
			rtE       <= '0;
			writeRegE <= '0;
			regWriteE <= 1'b0;
			memToRegE <= 1'b0;
		end else begin
			rsE       <= rsD;
			rtE       <= rtD;
			writeRegE <= writeRegD;
			regWriteE <= regWriteD;
			memToRegE <= memToRegD;
		end
	end

	// read data travelling with the execute tags
	always_ff @(posedge clk) begin
		if (flushE) begin
			rdAE <= '0;
			rdBE <= '0;
		end else begin
			rdAE <= rdAD;
			rdBE <= rdBD;
		end
	end

	// memory bank
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			writeRegM <= '0;
			regWriteM <= 1'b0;
			memToRegM <= 1'b0;
		end else begin
			writeRegM <= writeRegE;
			regWriteM <= regWriteE;
			memToRegM <= memToRegE;
		end
	end

	// writeback bank
	// load flag no longer needed past memory
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			writeRegW <= '0;
			regWriteW <= 1'b0;
		end else begin
			writeRegW <= writeRegM;
			regWriteW <= regWriteM;
		end
	end

	// a flushed slot must never write back
	assert property (@(posedge clk) disable iff (!rstN) flushE |=> !regWriteE)
		else $error("bubble in execute carries a register write");

	// a load always targets a register
	assert property (@(posedge clk) disable iff (!rstN) memToRegE |-> regWriteE)
		else $error("load in execute without register write");

endmodule

/* tb_pipeCtrl.sv */
`timescale 1ns/10ps

module tb_pipeCtrl;
	import pipeCtrl_pkg::*;

	// cycles in each random test
	localparam int NumCycles = 300;

	logic    clk;
	logic    rstN;
	// decode side stimulus
	regAddr  rsD;
	regAddr  rtD;
	regAddr  writeRegD;
	logic    regWriteD;
	logic    memToRegD;
	logic    branchD;
	logic    jrD;
	dataWord rdAD;
	dataWord rdBD;
	dataWord aluOutM;
	dataWord resultW;
	// dut responses
	logic    stallF;
	logic    stallD;
	logic    flushE;
	logic    jrStallRead;
	dataWord cmpAD;
	dataWord cmpBD;
	dataWord srcAE;
	dataWord srcBE;
	regAddr  writeRegW;
	logic    regWriteW;

	// model tag queues
	// index 0 execute, 1 memory, 2 writeback
	regAddr  mWr [3];
	logic    mRegW [3];
	logic    mMem [3];
	regAddr  mRsE;
	regAddr  mRtE;
	dataWord mRdAE;
	dataWord mRdBE;
	// expected hazard levels in the current cycle
	logic    expStall;
	logic    expFlush;

	string   testName;
	int      errCount;
	int      checkCount;
	int      hitCount;

	pipeCtrl i_dut (.*);

	always #4 clk = ~clk;

	// nonzero source about to be written by the given stage
	function automatic logic written(regAddr src, int stage);
		return mRegW[stage] && (src != 0) && (mWr[stage] == src);
	endfunction

	// newest value wins
	// memory before writeback
	function automatic dataWord exeOperand(regAddr src, dataWord rd);
		if (written(src, 1))
			return aluOutM;
		if (written(src, 2))
			return resultW;
		return rd;
	endfunction

	task automatic checkVal(string what, dataWord exp, dataWord act);
		checkCount++;
		assert (act === exp) else begin
			errCount++;
			$display("FAILED %s %s expected %h actual %h", testName, what, exp, act);
		end
	endtask

	task automatic checkAll(int mode);
		logic ldUse;
		logic brHaz;
		logic jrRd;
		logic jrWr;
		// load in execute feeding decode
		ldUse = mMem[0] && (mRtE == rsD || mRtE == rtD);
		// branch operands not ready in decode
		brHaz = branchD && ((mRegW[0] && (mWr[0] == rsD || mWr[0] == rtD)) ||
			(mMem[1] && (mWr[1] == rsD || mWr[1] == rtD)));
		jrRd = jrD && mMem[1] && (mWr[1] == rsD);
		jrWr = jrD && mRegW[0] && (mWr[0] == rsD);
		expStall = ldUse || brHaz || jrRd || jrWr;
		// jr write stall holds decode but sends no bubble
		expFlush = ldUse || brHaz || jrRd;
		checkVal("stallF", expStall, stallF);
		checkVal("stallD", expStall, stallD);
		checkVal("flushE", expFlush, flushE);
		checkVal("jrStallRead", jrRd, jrStallRead);
		checkVal("cmpAD", written(rsD, 1) ? aluOutM : rdAD, cmpAD);
		checkVal("cmpBD", written(rtD, 1) ? aluOutM : rdBD, cmpBD);
		checkVal("srcAE", exeOperand(mRsE, mRdAE), srcAE);
		checkVal("srcBE", exeOperand(mRtE, mRdBE), srcBE);
		checkVal("writeRegW", mWr[2], writeRegW);
		checkVal("regWriteW", mRegW[2], regWriteW);
		// target condition of each test
		case (mode)
			1: hitCount += written(mRsE, 1) || written(mRtE, 1);
			2: hitCount += ldUse;
			3: hitCount += brHaz;
			4: hitCount += jrWr;
			default: ;
		endcase
	endtask

	// model state after the coming rising edge
	task automatic advanceModel();
		// read data copy loads on every edge
		mRdAE = expFlush ? '0 : rdAD;
		mRdBE = expFlush ? '0 : rdBD;
		if (!rstN) begin
			for (int s = 0; s < 3; s++) begin
				mWr[s]   = '0;
				mRegW[s] = 1'b0;
				mMem[s]  = 1'b0;
			end
			mRsE = '0;
			mRtE = '0;
		end else begin
			for (int s = 2; s > 0; s--) begin
				mWr[s]   = mWr[s-1];
				mRegW[s] = mRegW[s-1];
				mMem[s]  = mMem[s-1];
			end
			// bubble on flush
			mWr[0]   = expFlush ? '0 : writeRegD;
			mRegW[0] = !expFlush && regWriteD;
			mMem[0]  = !expFlush && memToRegD;
			mRsE     = expFlush ? '0 : rsD;
			mRtE     = expFlush ? '0 : rtD;
		end
	endtask

	// small register range keeps hazards frequent
	task automatic driveInputs(int mode, logic rstVal, logic hold);
		rstN = rstVal;
		// fetch/decode register stand-in keeps the instruction on a stall
		if (!hold) begin
			rsD       = $urandom_range(3, 0);
			rtD       = $urandom_range(3, 0);
			memToRegD = (mode == 2) ? $urandom_range(1, 0) : ($urandom_range(7, 0) == 0);
			regWriteD = memToRegD || $urandom_range(1, 0);
			// a load writes its rt
			writeRegD = memToRegD ? rtD : $urandom_range(3, 0);
			branchD   = (mode == 3) && $urandom_range(1, 0);
			jrD       = (mode == 4) && $urandom_range(1, 0);
			// jalr writing its own rs would stall on itself forever
			if (jrD && writeRegD == rsD)
				writeRegD = rsD ^ 5'd1;
		end
		rdAD    = $urandom;
		rdBD    = $urandom;
		aluOutM = $urandom;
		resultW = $urandom;
	endtask

	// drive after the edge
	// check just before the next one
	task automatic stepCycle(int mode, logic rstVal);
		logic hold;
		// stall level in force at the coming edge
		hold = expStall;
		@(posedge clk);
		#1;
		driveInputs(mode, rstVal, hold);
		#6;
		checkAll(mode);
		advanceModel();
	endtask

	task automatic runTest(string name, int mode);
		testName = name;
		hitCount = 0;
		for (int i = 0; i < NumCycles; i++)
			stepCycle(mode, 1'b1);
		assert (hitCount > 0) else begin
			errCount++;
			$display("test %s never produced the hazard it targets", name);
		end
	endtask

	// hard stop for a stuck run
	initial begin
		#50us;
		$display("simulation ran past its time limit");
		$display("tests failed");
		$finish;
	end

	initial begin
		void'($urandom(12));
		clk        = 1'b0;
		rstN       = 1'b0;
		rsD        = '0;
		rtD        = '0;
		writeRegD  = '0;
		regWriteD  = 1'b0;
		memToRegD  = 1'b0;
		branchD    = 1'b0;
		jrD        = 1'b0;
		rdAD       = '0;
		rdBD       = '0;
		aluOutM    = '0;
		resultW    = '0;
		errCount   = 0;
		checkCount = 0;
		expStall   = 1'b0;
		expFlush   = 1'b0;
		testName   = "reset";
		advanceModel();
		// three edges in reset, then two quiet cycles
		for (int i = 0; i < 5; i++)
			stepCycle(0, i >= 3);
		runTest("exeForward", 1);
		runTest("loadUse", 2);
		runTest("branch", 3);
		runTest("jr", 4);
		$display("%0d checks, %0d errors", checkCount, errCount);
		if (errCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
